/* Makefile */
# Verilator build and run of the Ethernet TX frame buffer testbench

TOP = eth_tx_buffer_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f eth_tx_buffer.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* eth_tx_buffer.f */
verilog/eth_tx_pkg.sv
verilog/frame_loader.sv
verilog/frame_ram_arbiter.sv
verilog/frame_queue.sv
verilog/frame_sender.sv
verilog/eth_tx_buffer.sv
verif/tb_clock.sv
verif/eth_tx_buffer_tb.sv

/* verif/eth_tx_buffer_tb.sv */
`timescale 1ns/1ps
module eth_tx_buffer_tb;
	import eth_tx_pkg::*;

	localparam int BUF_DEPTH    = DEFAULT_BUF_DEPTH;
	localparam int QUEUE_DEPTH  = DEFAULT_QUEUE_DEPTH;
	localparam int PERIOD_NS    = 4;
	localparam int PAT_SIZE     = 128;
	localparam int DRAIN_CYCLES = 16;

	logic        tx_clk;
	logic        reset;
	logic        reg_wr;
	logic        reg_rd;
	reg_addr_t   reg_addr;
	word_t       reg_wdata;
	word_t       reg_rdata;
	logic        reg_err;
	logic        link_up;
	logic        tx_valid;
	word_t       tx_data;
	logic [3:0]  tx_strb;
	logic        tx_last;

	// Flat pattern words, see verif/tx_frame_patterns.mem
	word_t       pat_mem [PAT_SIZE];
	int          pat_words;
	int          pat_idx;
	int          tests_run;
	// Beats packed as {data, strb, last}
	logic [36:0] seen_beats [$];
	logic [36:0] exp_beats [$];
	logic [31:0] rand_state;
	int          pass_count;
	int          fail_count;

	tb_clock #(.RESET_CYCLES(3)) i_clock (.tx_clk(tx_clk), .reset(reset));

	eth_tx_buffer #(
		.BUF_DEPTH   (BUF_DEPTH),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_dut (
		.tx_clk    (tx_clk),
		.reset     (reset),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.reg_err   (reg_err),
		.link_up   (link_up),
		.tx_valid  (tx_valid),
		.tx_data   (tx_data),
		.tx_strb   (tx_strb),
		.tx_last   (tx_last)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Words the loader keeps, capped by the byte length
	function automatic int stored_words(input int len, input int nwords);
		int full;
		full = (len + 3) / 4;
		return (nwords < full) ? nwords : full;
	endfunction

	// 0 to 3 spare cycles between host accesses
	task automatic idle_gap();
		rand_state = lcg_next(rand_state);
		repeat (rand_state[17:16]) @(negedge tx_clk);
	endtask

	task automatic compare_beat(
		input word_t      got_data,
		input logic [3:0] got_strb,
		input logic       got_last,
		input word_t      exp_data,
		input logic [3:0] exp_strb,
		input logic       exp_last
	);
		if (got_data !== exp_data || got_strb !== exp_strb || got_last !== exp_last) begin
			fail_count++;
			$display("[FAIL] t=%0d ns: beat %h strb %b last %b, expected %h strb %b last %b",
				$time, got_data, got_strb, got_last, exp_data, exp_strb, exp_last);
		end else begin
			pass_count++;
		end
	endtask

	task automatic compare_reg(
		input word_t got_rdata,
		input logic  got_err,
		input word_t exp_rdata,
		input logic  exp_err
	);
		if (got_rdata !== exp_rdata || got_err !== exp_err) begin
			fail_count++;
			$display("[FAIL] t=%0d ns: reg addr %h rdata %h err %b, expected rdata %h err %b",
				$time, reg_addr, got_rdata, got_err, exp_rdata, exp_err);
		end else begin
			pass_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host register port, entered and left on a falling edge

	task automatic reg_access(
		input logic      is_write,
		input reg_addr_t addr,
		input word_t     wdata,
		input word_t     exp_rdata,
		input logic      exp_err
	);
		reg_wr    = is_write;
		reg_rd    = !is_write;
		reg_addr  = addr;
		reg_wdata = wdata;
		// Response is combinational, settled well before the rising edge
		#1;
		compare_reg(reg_rdata, reg_err, exp_rdata, exp_err);
		@(negedge tx_clk);
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		idle_gap();
	endtask

	task automatic load_frame(input int base);
		int i;
		int nwords;
		nwords = int'(pat_mem[base + 3]);
		reg_access(1'b1, REG_LENGTH, pat_mem[base + 2], '0, 1'b0);
		for (i = 0; i < nwords; i++)
			reg_access(1'b1, REG_TX_WORD, pat_mem[base + 4 + i], '0, 1'b0);
		reg_access(1'b1, REG_COMMIT, '0, '0, 1'b0);
	endtask

	// Full words first, the tail keeps len mod 4 low bytes
	task automatic expect_frame(input int base, input int stored);
		int         i;
		int         b;
		int         len;
		int         bytes;
		word_t      data;
		logic [3:0] strb;
		len = int'(pat_mem[base + 2]);
		for (i = 0; i < stored; i++) begin
			bytes = (len - 4 * i >= 4) ? 4 : len - 4 * i;
			data  = pat_mem[base + 4 + i];
			strb  = 4'b0000;
			for (b = 0; b < bytes; b++)
				strb[b] = 1'b1;
			for (b = bytes; b < 4; b++)
				data[8 * b +: 8] = 8'h00;
			exp_beats.push_back({data, strb, i == stored - 1});
		end
	endtask

	// Waits for every predicted beat, the watchdog bounds the wait
	task automatic check_stream();
		logic [36:0] got;
		logic [36:0] exp;
		while (seen_beats.size() < exp_beats.size())
			@(negedge tx_clk);
		while (exp_beats.size() > 0) begin
			got = seen_beats.pop_front();
			exp = exp_beats.pop_front();
			compare_beat(got[36:5], got[4:1], got[0], exp[36:5], exp[4:1], exp[0]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic check_register_map();
		int fails_before;
		fails_before = fail_count;
		link_up = 1'b0;
		reg_access(1'b0, REG_STAT, '0, 32'h0, 1'b0);
		link_up = 1'b1;
		reg_access(1'b0, REG_STAT, '0, 32'h1, 1'b0);
		// Status is read only, the others write only
		reg_access(1'b1, REG_STAT, 32'h3, 32'h0, 1'b1);
		reg_access(1'b0, REG_LENGTH, '0, 32'h0, 1'b1);
		reg_access(1'b0, REG_TX_WORD, '0, 32'h0, 1'b1);
		reg_access(1'b0, reg_addr_t'(8'h84), '0, 32'h0, 1'b1);
		reg_access(1'b1, reg_addr_t'(8'h84), 32'h5a5a_5a5a, 32'h0, 1'b1);
		$display("register map finished: %0d errors", fail_count - fails_before);
	endtask

	// One test is a run of records with the same id
	task automatic run_test();
		int   test_id;
		int   pending;
		int   stored;
		int   fails_before;
		logic link;
		logic drop_seen;
		test_id      = int'(pat_mem[pat_idx]);
		link         = pat_mem[pat_idx + 1][0];
		pending      = 0;
		drop_seen    = 1'b0;
		fails_before = fail_count;
		link_up      = link;
		while (pat_mem[pat_idx] == word_t'(test_id)) begin
			stored = stored_words(int'(pat_mem[pat_idx + 2]), int'(pat_mem[pat_idx + 3]));
			load_frame(pat_idx);
			if (stored > 0) begin
				// Queue slots only free up while the link is up
				if (!link && pending == QUEUE_DEPTH) begin
					drop_seen = 1'b1;
				end else begin
					pending++;
					expect_frame(pat_idx, stored);
				end
			end
			if (link)
				check_stream();
			pat_idx += 4 + int'(pat_mem[pat_idx + 3]);
		end
		if (!link) begin
			if (seen_beats.size() != 0) begin
				fail_count++;
				$display("%0d beats came out while the link was down", seen_beats.size());
				seen_beats.delete();
			end
			// Sticky drop reads once, then clears
			reg_access(1'b0, REG_STAT, '0, {30'h0, drop_seen, 1'b0}, 1'b0);
			reg_access(1'b0, REG_STAT, '0, 32'h0, 1'b0);
			link_up = 1'b1;
			check_stream();
		end
		repeat (DRAIN_CYCLES) @(negedge tx_clk);
		if (seen_beats.size() != 0) begin
			fail_count++;
			$display("%0d beats came out beyond the predicted stream", seen_beats.size());
			seen_beats.delete();
		end
		reg_access(1'b0, REG_STAT, '0, 32'h1, 1'b0);
		tests_run++;
		$display("frame test %0d finished: %0d frames sent, %0d errors",
			test_id, pending, fail_count - fails_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stream monitor, beats are stable at the falling edge

	always @(negedge tx_clk) begin
		if (!reset && tx_valid)
			seen_beats.push_back({tx_data, tx_strb, tx_last});
	end

	initial begin
		reg_wr     = 1'b0;
		reg_rd     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		link_up    = 1'b0;
		pass_count = 0;
		fail_count = 0;
		tests_run  = 0;
		pat_words  = 0;
		pat_idx    = 0;
		rand_state = 32'h29e7_bf54;
		$readmemh("verif/tx_frame_patterns.mem", pat_mem);
		// Walk the records to size the run
		while (pat_idx < PAT_SIZE - 4 && pat_mem[pat_idx] != '0)
			pat_idx += 4 + int'(pat_mem[pat_idx + 3]);
		pat_words = pat_idx + 1;
		pat_idx   = 0;
		while (reset !== 1'b0)
			@(negedge tx_clk);
		@(negedge tx_clk);
		check_register_map();
		while (pat_idx < PAT_SIZE - 4 && pat_mem[pat_idx] != '0)
			run_test();
		if (tests_run == 0) begin
			fail_count++;
			$display("no frame records were found in verif/tx_frame_patterns.mem");
		end
		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog scaled to the pattern length
	initial begin
		#1;
		#((pat_words * 8 + 200) * PERIOD_NS);
		$display("timeout: the stream did not finish within %0d cycles",
			pat_words * 8 + 200);
		$display("test failed");
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps
module tb_clock #(
	parameter int RESET_CYCLES = 3
) (
	output logic tx_clk,
	output logic reset
);
	// 4 ns period
	initial begin
		tx_clk = 1'b0;
		forever #2 tx_clk = ~tx_clk;
	end

	// Reset held over the first rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		@(negedge tx_clk);
		reset = 1'b0;
	end

endmodule

/* verif/tx_frame_patterns.mem */
// Columns, hex: test id, link up, length in bytes, word count, then the words
// One frame per line, a test is a run of lines with the same id, id 0 ends

// Aligned frame, then 13 bytes with a one byte tail
1 1 8 2 11223344 55667788
1 1 d 4 a1a2a3a4 b1b2b3b4 c1c2c3c4 d1d2d3d4

// Word past the length, an empty commit, a three byte frame
2 1 6 3 01020304 05060708 090a0b0c
2 1 0 2 deadbeef cafef00d
2 1 3 1 87654321

// Held while the link is down, sent in commit order
3 0 5 2 10203040 50607080
3 0 a 3 0badf00d 12345678 9abcdef0
3 0 4 1 fedcba98

// One more frame than the queue holds, the last is dropped
4 0 4 1 00c0ffee
4 0 8 2 11111111 22222222
4 0 2 1 0000abcd
4 0 5 2 33333333 44444444
4 0 6 2 55555555 66666666

// Normal traffic after the drop
5 1 7 2 77777777 88888888

0

/* verilog/eth_tx_buffer.sv */
`timescale 1ns/1ps
module eth_tx_buffer #(
	parameter int BUF_DEPTH   = eth_tx_pkg::DEFAULT_BUF_DEPTH,
	parameter int QUEUE_DEPTH = eth_tx_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                  tx_clk,
	input  logic                  reset,
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	input  eth_tx_pkg::reg_addr_t reg_addr,
	input  eth_tx_pkg::word_t     reg_wdata,
	output eth_tx_pkg::word_t     reg_rdata,
	output logic                  reg_err,
	input  logic                  link_up,
	output logic                  tx_valid,
	output eth_tx_pkg::word_t     tx_data,
	output logic [3:0]            tx_strb,
	output logic                  tx_last
);
	import eth_tx_pkg::*;

	// Loader write port
	logic                   ram_wr;
	ram_addr_t              ram_wr_addr;
	logic [RAM_ENTRY_W-1:0] ram_wr_data;

	// Sender read port
	logic                   ram_rd_req;
	ram_addr_t              ram_rd_addr;
	logic                   ram_rd_gnt;
	logic [RAM_ENTRY_W-1:0] ram_rd_data;
	logic                   ram_rd_valid;

	// Descriptor queue
	logic                   q_push;
	logic [DESC_W-1:0]      q_push_data;
	logic                   q_pop;
	logic [DESC_W-1:0]      q_head;
	logic                   q_empty;
	logic                   q_full;

	// Space return
	logic                   frame_done;
	wordcnt_t               done_words;

	//////////////////////////////////////////////////////////////////////////////
	// Host side

	frame_loader #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_loader (
		.tx_clk      (tx_clk),
		.reset       (reset),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.reg_err     (reg_err),
		.link_up     (link_up),
		.ram_wr      (ram_wr),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.q_push      (q_push),
		.q_push_data (q_push_data),
		.q_full      (q_full),
		.frame_done  (frame_done),
		.done_words  (done_words)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Shared storage

	frame_ram_arbiter #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_ram (
		.tx_clk       (tx_clk),
		.reset        (reset),
		.ram_wr       (ram_wr),
		.ram_wr_addr  (ram_wr_addr),
		.ram_wr_data  (ram_wr_data),
		.ram_rd_req   (ram_rd_req),
		.ram_rd_addr  (ram_rd_addr),
		.ram_rd_gnt   (ram_rd_gnt),
		.ram_rd_data  (ram_rd_data),
		.ram_rd_valid (ram_rd_valid)
	);

	frame_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_queue (
		.tx_clk      (tx_clk),
		.reset       (reset),
		.q_push      (q_push),
		.q_push_data (q_push_data),
		.q_pop       (q_pop),
		.q_head      (q_head),
		.q_empty     (q_empty),
		.q_full      (q_full)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Stream side

	frame_sender #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_sender (
		.tx_clk       (tx_clk),
		.reset        (reset),
		.link_up      (link_up),
		.q_head       (q_head),
		.q_empty      (q_empty),
		.q_pop        (q_pop),
		.ram_rd_req   (ram_rd_req),
		.ram_rd_addr  (ram_rd_addr),
		.ram_rd_gnt   (ram_rd_gnt),
		.ram_rd_data  (ram_rd_data),
		.ram_rd_valid (ram_rd_valid),
		.frame_done   (frame_done),
		.done_words   (done_words),
		.tx_valid     (tx_valid),
		.tx_data      (tx_data),
		.tx_strb      (tx_strb),
		.tx_last      (tx_last)
	);

endmodule

/* verilog/eth_tx_pkg.sv */
package eth_tx_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Data widths

	// Host and stream data word
	typedef logic [31:0] word_t;

	// Valid bytes in one stored word, 0 to 4
	typedef logic [2:0] bytecnt_t;

	// Frame length in bytes as written to REG_LENGTH
	typedef logic [10:0] framelen_t;

	// Frame length in words
	typedef logic [8:0] wordcnt_t;

	// Word address into the frame RAM
	typedef logic [7:0] ram_addr_t;

	// Host register address
	typedef logic [7:0] reg_addr_t;

	//////////////////////////////////////////////////////////////////////////////
	// Register map

	typedef enum logic [7:0] {
		REG_STAT    = 8'h00,	// [0] link up, [1] sticky drop, read clears drop
		REG_COMMIT  = 8'h20,	// any write sends the frame in progress
		REG_LENGTH  = 8'h40,	// frame length in bytes
		REG_TX_WORD = 8'h60	// append one word
	} regid_t;

	//////////////////////////////////////////////////////////////////////////////
	// Sizes

	localparam int DEFAULT_BUF_DEPTH   = 256;
	localparam int DEFAULT_QUEUE_DEPTH = 4;

	// RAM entry is {word, valid byte count}
	localparam int RAM_ENTRY_W = $bits(word_t) + $bits(bytecnt_t);

	// Descriptor is {start address, word count}
	localparam int DESC_W = $bits(ram_addr_t) + $bits(wordcnt_t);

endpackage

/* verilog/frame_loader.sv */
`timescale 1ns/1ps
module frame_loader #(
	parameter int BUF_DEPTH = eth_tx_pkg::DEFAULT_BUF_DEPTH
) (
	input  logic                               tx_clk,
	input  logic                               reset,
	input  logic                               reg_wr,
	input  logic                               reg_rd,
	input  eth_tx_pkg::reg_addr_t              reg_addr,
	input  eth_tx_pkg::word_t                  reg_wdata,
	output eth_tx_pkg::word_t                  reg_rdata,
	output logic                               reg_err,
	input  logic                               link_up,
	output logic                               ram_wr,
	output eth_tx_pkg::ram_addr_t              ram_wr_addr,
	output logic [eth_tx_pkg::RAM_ENTRY_W-1:0] ram_wr_data,
	output logic                               q_push,
	output logic [eth_tx_pkg::DESC_W-1:0]      q_push_data,
	input  logic                               q_full,
	input  logic                               frame_done,
	input  eth_tx_pkg::wordcnt_t               done_words
);
	import eth_tx_pkg::*;

	regid_t     reg_id;
	logic       wr_commit;
	logic       wr_length;
	logic       wr_word;
	logic       rd_stat;
	framelen_t  bytes_left;
	bytecnt_t   word_bytes;
	ram_addr_t  wr_ptr;
	ram_addr_t  next_ptr;
	ram_addr_t  frame_start;
	wordcnt_t   frame_words;
	wordcnt_t   used_words;
	wordcnt_t   used_next;
	logic [9:0] occupied;
	logic       ram_room;
	logic       frame_bad;
	logic       frame_drop;
	logic       commit_ok;
	logic       drop_flag;

	//////////////////////////////////////////////////////////////////////////////
	// Register decode, answered in the strobe cycle

	always_comb begin
		reg_id    = regid_t'(reg_addr);
		wr_commit = 1'b0;
		wr_length = 1'b0;
		wr_word   = 1'b0;
		rd_stat   = 1'b0;
		reg_err   = 1'b0;
		reg_rdata = '0;
		if (reg_wr) begin
			case (reg_id)
				REG_COMMIT:  wr_commit = 1'b1;
				REG_LENGTH:  wr_length = 1'b1;
				REG_TX_WORD: wr_word   = 1'b1;
				// Status is read only, rest unmapped
				default:     reg_err   = 1'b1;
			endcase
		end
		if (reg_rd) begin
			// Only status reads back
			if (reg_id == REG_STAT) begin
				rd_stat   = 1'b1;
				reg_rdata = {30'h0, drop_flag, link_up};
			end else begin
				reg_err = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Length, space and commit checks

	// Full word or the tail remainder
	assign word_bytes = (bytes_left >= framelen_t'(4)) ? bytecnt_t'(4) : bytecnt_t'(bytes_left);
	assign next_ptr   = (wr_ptr == ram_addr_t'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

	// Committed frames plus the one being built
	assign occupied   = 10'(used_words) + 10'(frame_words);
	assign ram_room   = occupied < 10'(BUF_DEPTH);

	// Drop on RAM overflow, or a real frame with no queue slot
	assign frame_drop = wr_commit && (frame_bad || (q_full && frame_words != '0));
	assign commit_ok  = wr_commit && !frame_drop && frame_words != '0;

	always_comb begin
		used_next = used_words;
		if (commit_ok)
			used_next = used_next + frame_words;
		// Sender hands back space once a frame is out
		if (frame_done)
			used_next = used_next - done_words;
	end

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			bytes_left  <= '0;
			wr_ptr      <= '0;
			frame_start <= '0;
			frame_words <= '0;
			used_words  <= '0;
			frame_bad   <= 1'b0;
			drop_flag   <= 1'b0;
			ram_wr      <= 1'b0;
			q_push      <= 1'b0;
		end else begin
			ram_wr     <= 1'b0;
			q_push     <= 1'b0;
			used_words <= used_next;
			if (rd_stat)
				drop_flag <= 1'b0;
			if (wr_length)
				bytes_left <= framelen_t'(reg_wdata);
			// Words past the stated length are ignored
			if (wr_word && bytes_left != '0) begin
				bytes_left <= bytes_left - framelen_t'(word_bytes);
				if (ram_room) begin
					ram_wr      <= 1'b1;
					wr_ptr      <= next_ptr;
					frame_words <= frame_words + 1'b1;
				end else begin
					frame_bad <= 1'b1;
				end
			end
			if (wr_commit) begin
				bytes_left  <= '0;
				frame_words <= '0;
				frame_bad   <= 1'b0;
				q_push      <= commit_ok;
				if (frame_drop) begin
					// Rewind over the discarded words
					wr_ptr    <= frame_start;
					drop_flag <= 1'b1;
				end else begin
					frame_start <= wr_ptr;
				end
			end
		end
	end

	// Write and descriptor payloads, one cycle behind the strobe
	always_ff @(posedge tx_clk) begin
		if (wr_word) begin
			ram_wr_addr <= wr_ptr;
			ram_wr_data <= {reg_wdata, word_bytes};
		end
		if (wr_commit)
			q_push_data <= {frame_start, frame_words};
	end

	// Full queue must have been caught at commit
	assert property (@(posedge tx_clk) disable iff (reset)
		q_push |-> !q_full);

endmodule

/* verilog/frame_queue.sv */
`timescale 1ns/1ps
module frame_queue #(
	parameter int QUEUE_DEPTH = eth_tx_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                          tx_clk,
	input  logic                          reset,
	input  logic                          q_push,
	input  logic [eth_tx_pkg::DESC_W-1:0] q_push_data,
	input  logic                          q_pop,
	output logic [eth_tx_pkg::DESC_W-1:0] q_head,
	output logic                          q_empty,
	output logic                          q_full
);
	import eth_tx_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [DESC_W-1:0] slots [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              do_push;
	logic              do_pop;

	// Circular wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = q_push && !q_full;
	assign do_pop  = q_pop && !q_empty;

	// Occupancy flags
	assign q_empty = count == '0;
	assign q_full  = count == CNT_W'(QUEUE_DEPTH);

	// Head comes straight from the slot flops
	assign q_head  = slots[rd_ptr];

	//////////////////////////////////////////////////////////////////////////////
	// Pointers and count

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= bump(wr_ptr);
			if (do_pop)
				rd_ptr <= bump(rd_ptr);
			// Simultaneous push and pop leave count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Descriptor storage
	always_ff @(posedge tx_clk) begin
		if (do_push)
			slots[wr_ptr] <= q_push_data;
	end

	// Sender only pops a descriptor it has seen
	assert property (@(posedge tx_clk) disable iff (reset)
		q_pop |-> !q_empty);

	// Loader checks fullness before committing
	assert property (@(posedge tx_clk) disable iff (reset)
		q_push |-> !q_full);

endmodule

/* verilog/frame_ram_arbiter.sv */
`timescale 1ns/1ps
module frame_ram_arbiter #(
	parameter int BUF_DEPTH = eth_tx_pkg::DEFAULT_BUF_DEPTH
) (
	input  logic                               tx_clk,
	input  logic                               reset,
	input  logic                               ram_wr,
	input  eth_tx_pkg::ram_addr_t              ram_wr_addr,
	input  logic [eth_tx_pkg::RAM_ENTRY_W-1:0] ram_wr_data,
	input  logic                               ram_rd_req,
	input  eth_tx_pkg::ram_addr_t              ram_rd_addr,
	output logic                               ram_rd_gnt,
	output logic [eth_tx_pkg::RAM_ENTRY_W-1:0] ram_rd_data,
	output logic                               ram_rd_valid
);
	import eth_tx_pkg::*;

	// Word plus valid byte count per entry
	logic [RAM_ENTRY_W-1:0] frame_mem [BUF_DEPTH];

	//////////////////////////////////////////////////////////////////////////////
	// Port arbitration

	// Loader write always wins, read waits
	assign ram_rd_gnt = ram_rd_req && !ram_wr;

	//////////////////////////////////////////////////////////////////////////////
	// Single port RAM

	always_ff @(posedge tx_clk) begin
		if (ram_wr)
			frame_mem[ram_wr_addr] <= ram_wr_data;
		else if (ram_rd_req)
			// Granted read, data out next cycle
			ram_rd_data <= frame_mem[ram_rd_addr];
	end

	// Read valid one cycle after the grant
	always_ff @(posedge tx_clk) begin
		if (reset)
			ram_rd_valid <= 1'b0;
		else
			ram_rd_valid <= ram_rd_gnt;
	end

	// Sender keeps its request steady until granted
	assert property (@(posedge tx_clk) disable iff (reset)
		ram_rd_req && !ram_rd_gnt |=> ram_rd_req && $stable(ram_rd_addr));

endmodule

/* verilog/frame_sender.sv */
`timescale 1ns/1ps
module frame_sender #(
	parameter int BUF_DEPTH = eth_tx_pkg::DEFAULT_BUF_DEPTH
) (
	input  logic                               tx_clk,
	input  logic                               reset,
	input  logic                               link_up,
	input  logic [eth_tx_pkg::DESC_W-1:0]      q_head,
	input  logic                               q_empty,
	output logic                               q_pop,
	output logic                               ram_rd_req,
	output eth_tx_pkg::ram_addr_t              ram_rd_addr,
	input  logic                               ram_rd_gnt,
	input  logic [eth_tx_pkg::RAM_ENTRY_W-1:0] ram_rd_data,
	input  logic                               ram_rd_valid,
	output logic                               frame_done,
	output eth_tx_pkg::wordcnt_t               done_words,
	output logic                               tx_valid,
	output eth_tx_pkg::word_t                  tx_data,
	output logic [3:0]                         tx_strb,
	output logic                               tx_last
);
	import eth_tx_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		READ,
		DRAIN
	} state_t;

	state_t     state;
	wordcnt_t   words_left;
	wordcnt_t   frame_words;
	word_t      rd_word;
	bytecnt_t   rd_bytes;
	word_t      beat_data;
	logic [3:0] beat_strb;

	//////////////////////////////////////////////////////////////////////////////
	// Beat formatting

	always_comb begin
		rd_word  = ram_rd_data[RAM_ENTRY_W-1 -: $bits(word_t)];
		rd_bytes = ram_rd_data[$bits(bytecnt_t)-1:0];
		// Low strobes per valid byte, upper bytes zeroed
		for (int i = 0; i < 4; i++) begin
			beat_strb[i]        = bytecnt_t'(i) < rd_bytes;
			beat_data[8*i +: 8] = beat_strb[i] ? rd_word[8*i +: 8] : 8'h00;
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Read FSM, one word in flight at a time

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			state       <= IDLE;
			q_pop       <= 1'b0;
			ram_rd_req  <= 1'b0;
			ram_rd_addr <= '0;
			words_left  <= '0;
			frame_words <= '0;
		end else begin
			q_pop <= 1'b0;
			case (state)
				IDLE: begin
					// Hold frames back while the link is down
					if (!q_empty && link_up) begin
						ram_rd_addr <= q_head[DESC_W-1 -: $bits(ram_addr_t)];
						words_left  <= q_head[$bits(wordcnt_t)-1:0];
						frame_words <= q_head[$bits(wordcnt_t)-1:0];
						q_pop       <= 1'b1;
						state       <= LOAD;
					end
				end
				LOAD: begin
					// Pop settles in the queue here
					ram_rd_req <= 1'b1;
					state      <= READ;
				end
				READ: begin
					// Loader writes may hold us off
					if (ram_rd_gnt) begin
						ram_rd_req <= 1'b0;
						state      <= DRAIN;
					end
				end
				DRAIN: begin
					if (ram_rd_valid) begin
						words_left <= words_left - 1'b1;
						if (words_left == wordcnt_t'(1)) begin
							state <= IDLE;
						end else begin
							// Next word, wrap at end of buffer
							ram_rd_addr <= (ram_rd_addr == ram_addr_t'(BUF_DEPTH - 1)) ?
								'0 : ram_rd_addr + 1'b1;
							ram_rd_req  <= 1'b1;
							state       <= READ;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Stream output

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			tx_valid   <= 1'b0;
			tx_last    <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			tx_valid   <= ram_rd_valid;
			tx_last    <= ram_rd_valid && words_left == wordcnt_t'(1);
			// Space goes back to the loader after the last beat
			frame_done <= tx_valid && tx_last;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (ram_rd_valid) begin
			tx_data <= beat_data;
			tx_strb <= beat_strb;
		end
		if (tx_valid && tx_last)
			done_words <= frame_words;
	end

endmodule
